/* bench/sifhTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sifhSettings_settings.svh"

module sifhTb;
    import sifhPkg::*;

    localparam int Nbins = `SIFH_NBINS;
    // sweep plus window latency, with margin
    localparam int WaitLimit = Nbins + 20;
    // record tags of the tests file
    localparam logic [15:0] TagNote   = "//";
    localparam logic [15:0] TagEvent  = "ev";
    localparam logic [15:0] TagFrame  = "fr";
    localparam logic [15:0] TagDrop   = "dr";
    localparam logic [15:0] TagRandom = "rn";

    logic     clk;
    logic     rstN;
    logic     eventValid;
    binIdxT   eventBin;
    logic     frameEnd;
    logic     busy;
    binIdxT   peakBin;
    countT    peakCount;
    logic     windowValid;
    fineTimeT thMinus;
    fineTimeT thPositive;
    fineTimeT delta;
    countT    dropCount;

    int errors;
    int checks;
    int frameCycles;
    int seed;
    // events accepted since the last sweep, per bin
    int tally [Nbins];

    sifhTop dut_i (
        .clk         (clk),
        .rstN        (rstN),
        .eventValid  (eventValid),
        .eventBin    (eventBin),
        .frameEnd    (frameEnd),
        .busy        (busy),
        .peakBin     (peakBin),
        .peakCount   (peakCount),
        .windowValid (windowValid),
        .thMinus     (thMinus),
        .thPositive  (thPositive),
        .delta       (delta),
        .dropCount   (dropCount)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    // gating window around a peak bin, in fine-time units
    function automatic void expectedWindow(input int bin, output int lo, output int hi);
        int ch;
        int sb;
        ch = bin << (`SIFH_NP - `SIFH_NB);
        sb = 1 << (`SIFH_NB - 1);
        if (ch >= (1 << `SIFH_NP) - 1 - sb) begin
            hi = (1 << `SIFH_NP) - (1 << `SIFH_NB);
            lo = hi - 2 * sb;
        end else if (ch <= sb) begin
            lo = 0;
            hi = 2 * sb;
        end else begin
            lo = ch - sb;
            hi = ch + sb;
        end
    endfunction

    function automatic void tallyPeak(output int bin, output int count);
        bin = 0;
        count = 0;
        for (int i = 0; i < Nbins; i++) begin
            // strict compare, lowest bin keeps a tie
            if (tally[binIdxT'(i)] > count) begin
                bin = i;
                count = tally[binIdxT'(i)];
            end
        end
    endfunction

    // back-to-back when called on consecutive cycles
    task automatic sendEvent(input int bin);
        @(posedge clk);
        eventValid <= 1'b1;
        eventBin   <= binIdxT'(bin);
        tally[binIdxT'(bin)] = tally[binIdxT'(bin)] + 1;
    endtask

    // frame end, optional events into the running sweep, then window checks
    task automatic runFrame(input int expBin, input int expCount, input int dropN,
                            input int dropBin, input bit checkPeak);
        int sent;
        int dropBefore;
        int lo;
        int hi;
        bit busySeen;
        bit seen;
        sent = 0;
        busySeen = 1'b0;
        seen = 1'b0;
        frameCycles = 0;
        dropBefore = int'(dropCount);
        @(posedge clk);
        eventValid <= 1'b0;
        frameEnd   <= 1'b1;
        while (!seen && frameCycles < WaitLimit) begin
            @(posedge clk);
            frameEnd <= 1'b0;
            // these hit the sweep and get refused
            if (busySeen && sent < dropN) begin
                eventValid <= 1'b1;
                eventBin   <= binIdxT'(dropBin);
                sent++;
            end else begin
                eventValid <= 1'b0;
            end
            frameCycles++;
            @(negedge clk);
            busySeen = busySeen || busy;
            if (frameCycles == 1 || frameCycles == Nbins + 1) begin
                compare(32'(busy), 1, "busy during sweep");
            end
            if (frameCycles == Nbins + 2) begin
                compare(32'(busy), 0, "busy after peak done");
            end
            seen = windowValid;
        end
        if (!seen) begin
            errors++;
            $display("timeout: no window valid within %0d cycles of frame end", WaitLimit);
        end else begin
            compare(frameCycles, Nbins + 3, "frame end to window valid latency");
            compare(int'(dropCount) - dropBefore, dropN, "dropped events");
            if (checkPeak) begin
                compare(32'(peakBin), expBin, "peak bin");
                compare(32'(peakCount), expCount, "peak count");
                expectedWindow(expBin, lo, hi);
                compare(32'(thMinus), lo, "window lower bound");
                compare(32'(thPositive), hi, "window upper bound");
                compare(32'(delta), lo, "window delta");
            end
        end
        // sweep emptied every bin
        tally = '{default: 0};
    endtask

    initial begin : stimulus
        int fd;
        int code;
        int a;
        int b;
        int pBin;
        int pCount;
        logic [15:0]      tag;
        logic [8*200-1:0] note;
        errors = 0;
        checks = 0;
        seed = 32'h2693_d298;
        tally = '{default: 0};
        rstN = 1'b0;
        eventValid = 1'b0;
        eventBin = '0;
        frameEnd = 1'b0;
        repeat (16) begin
            @(posedge clk);
        end
        rstN <= 1'b1;
        @(negedge clk);
        compare(32'(busy), 0, "busy after reset");
        compare(32'(windowValid), 0, "window valid after reset");
        compare(32'(peakCount), 0, "peak count after reset");
        compare(32'(dropCount), 0, "drop count after reset");
        // bin memory has no reset, one sweep empties it
        runFrame(0, 0, 0, 0, 1'b0);
        fd = $fopen("bench/sifhTests.dat", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the tests file bench/sifhTests.dat");
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == TagNote) begin
                    code = $fgets(note, fd);
                end else if (tag == TagEvent) begin
                    code = $fscanf(fd, "%d", a);
                    compare(code, 1, "fields of an ev record");
                    sendEvent(a);
                end else if (tag == TagFrame) begin
                    code = $fscanf(fd, "%d %d", a, b);
                    compare(code, 2, "fields of a fr record");
                    runFrame(a, b, 0, 0, 1'b1);
                end else if (tag == TagDrop) begin
                    // a events to bin b while busy, peak from earlier events only
                    code = $fscanf(fd, "%d %d", a, b);
                    compare(code, 2, "fields of a dr record");
                    tallyPeak(pBin, pCount);
                    runFrame(pBin, pCount, a, b, 1'b1);
                end else if (tag == TagRandom) begin
                    code = $fscanf(fd, "%d", a);
                    compare(code, 1, "fields of an rn record");
                    repeat (a) begin
                        sendEvent($random(seed) & (Nbins - 1));
                    end
                    tallyPeak(pBin, pCount);
                    runFrame(pBin, pCount, 0, 0, 1'b1);
                end else begin
                    errors++;
                    $display("unknown record tag in the tests file");
                end
            end
            $fclose(fd);
        end
        @(posedge clk);
        eventValid <= 1'b0;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/sifhTests.dat */
// ev <bin> | fr <peakBin> <peakCount> | dr <events> <bin> | rn <events>
// dr sends its events during the sweep, rn sends random bins then a frame end
// back-to-back hits on bin 5 go through forwarding
ev 5
ev 5
ev 5
ev 5
ev 12
ev 12
ev 40
fr 5 4
// second frame end, sweep left nothing behind
fr 0 0
// tie between 9 and 30
ev 30
ev 9
ev 30
ev 9
fr 9 2
// bin 1, just above the low clamp
ev 1
ev 1
fr 1 2
// top bin
ev 63
ev 2
ev 63
fr 63 2
// middle bin, then drops into the sweep
ev 33
ev 33
ev 33
dr 7 33
fr 0 0
rn 200

/* design/binRam.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sifhSettings_settings.svh"

module binRam (
    input  logic            clk,
    input  logic            we,
    input  sifhPkg::binIdxT addr,
    input  sifhPkg::countT  wdata,
    output sifhPkg::countT  rdata
);
    import sifhPkg::*;

    // one count per coarse bin
    countT  store [`SIFH_NBINS];
    // address of the previous access
    // the write half of a read-modify-write lands here
    binIdxT addrQ;

    always_ff @(posedge clk) begin
        addrQ <= addr;
    end

    // registered read, old data when the same bin is written this cycle
    always_ff @(posedge clk) begin
        rdata <= store[addr];
    end

    // write lands at the edge
    // so a new read and the previous write-back share one cycle
    always_ff @(posedge clk) begin
        if (we) begin
            store[addrQ] <= wdata;
        end
    end

endmodule

`default_nettype wire

/* design/histAccum.sv */
`timescale 1ns/1ps
`default_nettype none

module histAccum (
    input  logic            clk,
    input  logic            rstN,
    input  logic            eventValid,
    input  sifhPkg::binIdxT eventBin,
    memPortIf.requester     mem,
    output sifhPkg::countT  dropCount
);
    import sifhPkg::*;

    // read issued last cycle, data on mem.rdata now
    logic   rdValid;
    binIdxT rdBin;
    // bin written last cycle
    // the RAM read of that bin in the same cycle was stale
    logic   pendValid;
    binIdxT pendBin;
    countT  pendCount;
    // increment path
    countT  baseCount;
    countT  nextCount;
    logic   eventLost;

    // every event asks for a read of its bin
    assign mem.req  = eventValid;
    assign mem.addr = eventBin;

    // forward the pending value on a back-to-back hit
    always_comb begin
        if (pendValid && (pendBin == rdBin)) begin
            baseCount = pendCount;
        end else begin
            baseCount = mem.rdata;
        end
    end

    // saturate at all ones
    always_comb begin
        if (baseCount == '1) begin
            nextCount = baseCount;
        end else begin
            nextCount = countT'(baseCount + 1'b1);
        end
    end

    // write-back one cycle after the read
    assign mem.we    = rdValid;
    assign mem.wdata = nextCount;

    // refused by the arbiter, i.e. sweep in progress
    assign eventLost = eventValid && !mem.gnt;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rdValid   <= 1'b0;
            pendValid <= 1'b0;
            dropCount <= '0;
        end else begin
            rdValid   <= eventValid && mem.gnt;
            pendValid <= rdValid;
            if (eventLost && (dropCount != '1)) begin
                dropCount <= countT'(dropCount + 1'b1);
            end
        end
    end

    // payload, qualified by the valid flags above
    always_ff @(posedge clk) begin
        rdBin     <= eventBin;
        pendBin   <= rdBin;
        pendCount <= nextCount;
    end

endmodule

`default_nettype wire

/* design/memArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module memArbiter (
    input  logic            clk,
    input  logic            rstN,
    memPortIf.arbiter       accPort,
    memPortIf.arbiter       sweepPort,
    output logic            ramWe,
    output sifhPkg::binIdxT ramAddr,
    output sifhPkg::countT  ramWdata,
    input  sifhPkg::countT  ramRdata
);
    import sifhPkg::*;

    // owner of this cycle's read slot
    memOwnerT owner;
    // owner of last cycle's read, gets the data and the write-back
    memOwnerT ownerQ;

    // sweep has absolute priority while it runs
    assign owner         = sweepPort.req ? ownerSweep : ownerAcc;
    assign sweepPort.gnt = sweepPort.req;
    assign accPort.gnt   = accPort.req && !sweepPort.req;

    // read address from the current owner
    assign ramAddr = (owner == ownerSweep) ? sweepPort.addr : accPort.addr;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ownerQ <= ownerAcc;
        end else begin
            ownerQ <= owner;
        end
    end

    // write-back follows the port that read last cycle
    assign ramWe    = (ownerQ == ownerSweep) ? sweepPort.we : accPort.we;
    assign ramWdata = (ownerQ == ownerSweep) ? sweepPort.wdata : accPort.wdata;

    // return data only to the port that asked for it
    assign accPort.rdata   = (ownerQ == ownerAcc) ? ramRdata : '0;
    assign sweepPort.rdata = (ownerQ == ownerSweep) ? ramRdata : '0;

    // single owner per slot, and the two requesters never
    // both hold a write-back in the same cycle
    assert property (@(posedge clk) disable iff (!rstN)
        !(accPort.gnt && sweepPort.gnt) && !(accPort.we && sweepPort.we));

endmodule

`default_nettype wire

/* design/memPortIf.sv */
`timescale 1ns/1ps
`default_nettype none

// one requester's path into the bin memory
// req+gnt in cycle t reads addr, rdata valid in t+1
// we/wdata in t+1 write back to the bin read in t
interface memPortIf;
    import sifhPkg::*;

    logic   req;
    logic   we;
    binIdxT addr;
    countT  wdata;
    logic   gnt;
    countT  rdata;

    // accumulator or sweep side
    modport requester (output req, output we, output addr, output wdata,
                       input gnt, input rdata);

    // arbiter side
    modport arbiter (input req, input we, input addr, input wdata,
                     output gnt, output rdata);

endinterface

`default_nettype wire

/* design/peakSweep.sv */
`timescale 1ns/1ps
`default_nettype none

module peakSweep (
    input  logic            clk,
    input  logic            rstN,
    input  logic            frameEnd,
    memPortIf.requester     mem,
    output logic            busy,
    output sifhPkg::binIdxT peakBin,
    output sifhPkg::countT  peakCount,
    output logic            peakDone
);
    import sifhPkg::*;

    sweepStateT state;
    // bin being read this cycle
    binIdxT     rdAddr;
    // bin whose data is on mem.rdata
    binIdxT     cmpAddr;
    logic       cmpValid;
    // running maximum
    countT      maxCount;
    binIdxT     maxBin;
    // maximum including the bin compared now
    logic       takeNew;
    countT      bestCount;
    binIdxT     bestBin;

    assign busy = (state != sweepIdle);

    // hold the memory for the whole sweep, final write-back included
    assign mem.req  = busy;
    assign mem.addr = rdAddr;

    // clear each bin in the cycle after its read
    assign mem.we    = cmpValid;
    assign mem.wdata = '0;

    // strict compare, first (lowest) bin wins a tie
    assign takeNew   = cmpValid && (mem.rdata > maxCount);
    assign bestCount = takeNew ? mem.rdata : maxCount;
    assign bestBin   = takeNew ? cmpAddr : maxBin;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= sweepIdle;
            rdAddr    <= '0;
            cmpValid  <= 1'b0;
            maxCount  <= '0;
            maxBin    <= '0;
            peakBin   <= '0;
            peakCount <= '0;
            peakDone  <= 1'b0;
        end else begin
            peakDone <= 1'b0;
            cmpValid <= (state == sweepRead) && mem.gnt;
            maxCount <= bestCount;
            maxBin   <= bestBin;
            case (state)
                sweepIdle: begin
                    // frame end while busy is not seen here
                    if (frameEnd) begin
                        state    <= sweepRead;
                        rdAddr   <= '0;
                        maxCount <= '0;
                        maxBin   <= '0;
                    end
                end
                sweepRead: begin
                    rdAddr <= binIdxT'(rdAddr + 1'b1);
                    if (rdAddr == '1) begin
                        state <= sweepFinish;
                    end
                end
                sweepFinish: begin
                    // last bin compared now, publish
                    state     <= sweepIdle;
                    peakBin   <= bestBin;
                    peakCount <= bestCount;
                    peakDone  <= 1'b1;
                end
                default: begin
                    state <= sweepIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        cmpAddr <= rdAddr;
    end

endmodule

`default_nettype wire

/* design/sifhPkg.sv */
`default_nettype none

`include "sifhSettings_settings.svh"

package sifhPkg;

    // coarse arrival-time bin
    typedef logic [`SIFH_NB-1:0] binIdxT;

    // fine-time window bound
    typedef logic [`SIFH_NP-1:0] fineTimeT;

    // bin occupancy
    typedef logic [`SIFH_CNT_W-1:0] countT;

    // peak sweep FSM
    typedef enum logic [1:0] {
        sweepIdle,
        sweepRead,
        sweepFinish
    } sweepStateT;

    // which requester owns the memory slot
    typedef enum logic {
        ownerAcc,
        ownerSweep
    } memOwnerT;

endpackage

`default_nettype wire

/* design/sifhSettings_settings.svh */
`ifndef SIFH_SETTINGS_SVH
`define SIFH_SETTINGS_SVH

// coarse histogram bits, one bin per code
`define SIFH_NB 6

// fine-time width of the gating window bounds
// must stay wider than SIFH_NB
`define SIFH_NP 16

// per-bin event count, saturates at all ones
`define SIFH_CNT_W 12

// number of bins in the shared memory
`define SIFH_NBINS (2 ** `SIFH_NB)

`endif

/* design/sifhTop.sv */
`timescale 1ns/1ps
`default_nettype none

module sifhTop (
    input  logic              clk,
    input  logic              rstN,
    input  logic              eventValid,
    input  sifhPkg::binIdxT   eventBin,
    input  logic              frameEnd,
    output logic              busy,
    output sifhPkg::binIdxT   peakBin,
    output sifhPkg::countT    peakCount,
    output logic              windowValid,
    output sifhPkg::fineTimeT thMinus,
    output sifhPkg::fineTimeT thPositive,
    output sifhPkg::fineTimeT delta,
    output sifhPkg::countT    dropCount
);
    import sifhPkg::*;

    // memory side of the arbiter
    logic   ramWe;
    binIdxT ramAddr;
    countT  ramWdata;
    countT  ramRdata;
    // sweep result strobe into the window block
    logic   peakDone;

    // requester ports into the shared bin memory
    memPortIf accPort ();
    memPortIf sweepPort ();

    // photon events, one per cycle
    histAccum accum_i (
        .clk        (clk),
        .rstN       (rstN),
        .eventValid (eventValid),
        .eventBin   (eventBin),
        .mem        (accPort.requester),
        .dropCount  (dropCount)
    );

    // frame end scan, finds the peak and clears the bins
    peakSweep sweep_i (
        .clk       (clk),
        .rstN      (rstN),
        .frameEnd  (frameEnd),
        .mem       (sweepPort.requester),
        .busy      (busy),
        .peakBin   (peakBin),
        .peakCount (peakCount),
        .peakDone  (peakDone)
    );

    memArbiter arb_i (
        .clk       (clk),
        .rstN      (rstN),
        .accPort   (accPort.arbiter),
        .sweepPort (sweepPort.arbiter),
        .ramWe     (ramWe),
        .ramAddr   (ramAddr),
        .ramWdata  (ramWdata),
        .ramRdata  (ramRdata)
    );

    binRam ram_i (
        .clk   (clk),
        .we    (ramWe),
        .addr  (ramAddr),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

    // gating window from the peak bin
    windowCalc window_i (
        .clk         (clk),
        .rstN        (rstN),
        .peakDone    (peakDone),
        .peakBin     (peakBin),
        .thMinus     (thMinus),
        .thPositive  (thPositive),
        .delta       (delta),
        .windowValid (windowValid)
    );

endmodule

`default_nettype wire

/* design/windowCalc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sifhSettings_settings.svh"

module windowCalc (
    input  logic              clk,
    input  logic              rstN,
    input  logic              peakDone,
    input  sifhPkg::binIdxT   peakBin,
    output sifhPkg::fineTimeT thMinus,
    output sifhPkg::fineTimeT thPositive,
    output sifhPkg::fineTimeT delta,
    output logic              windowValid
);
    import sifhPkg::*;

    // half window SB and full window 2*SB
    localparam fineTimeT HalfSpan = fineTimeT'(2 ** (`SIFH_NB - 1));
    localparam fineTimeT FullSpan = fineTimeT'(2 ** `SIFH_NB);
    // top-side clamp threshold, all ones minus SB
    localparam fineTimeT HighClamp = fineTimeT'(2 ** `SIFH_NP - 1) - HalfSpan;
    // upper bound used when clamped at the top
    localparam fineTimeT TopPositive = fineTimeT'(2 ** `SIFH_NP - 2 ** `SIFH_NB);

    // peak bin in fine-time units
    fineTimeT chTime;
    fineTimeT minNext;
    fineTimeT posNext;

    assign chTime = {peakBin, {(`SIFH_NP - `SIFH_NB){1'b0}}};

    // window around the peak, pinned inside the fine-time range
    always_comb begin
        if (chTime >= HighClamp) begin
            posNext = TopPositive;
            minNext = TopPositive - FullSpan;
        end else if (chTime <= HalfSpan) begin
            minNext = '0;
            posNext = FullSpan;
        end else begin
            minNext = chTime - HalfSpan;
            posNext = chTime + HalfSpan;
        end
    end

    // bounds held until the next peak
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            thMinus     <= '0;
            thPositive  <= '0;
            delta       <= '0;
            windowValid <= 1'b0;
        end else begin
            windowValid <= peakDone;
            if (peakDone) begin
                thMinus    <= minNext;
                thPositive <= posNext;
                delta      <= minNext;
            end
        end
    end

    // each window is exactly 2*SB wide
    assert property (@(posedge clk) disable iff (!rstN)
        windowValid |-> (fineTimeT'(thPositive - thMinus) == FullSpan));

endmodule

`default_nettype wire

/* project.f */
+incdir+design
design/sifhPkg.sv
design/memPortIf.sv
design/binRam.sv
design/memArbiter.sv
design/histAccum.sv
design/peakSweep.sv
design/windowCalc.sv
design/sifhTop.sv
bench/sifhTb.sv

/* run.sh */
#!/usr/bin/env bash
# build the histogram testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

logFile=sim.log
rm -rf obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module sifhTb -f project.f -o sifhSim

./obj_dir/sifhSim > "$logFile" 2>&1
cat "$logFile"

if grep -q "CHECKS FAILED" "$logFile"; then
    echo "simulation reported failures, see $logFile"
    exit 1
fi
echo "simulation finished without failures"
